//--- logic/dd_bus_cfg.svh
/* Bus controller widths and address map constants */

`ifndef DD_BUS_CFG_SVH
`define DD_BUS_CFG_SVH

// ROM bank register width
`define DD_BANK_W     3
// Scroll position, 8 bits plus the misc high bit
`define DD_SCROLL_W   9
// Address shared with RAM and video devices
`define DD_AB_W       13
// Full ROM address
`define DD_ROM_AW     18

// Upper ROM address bits for each window
`define DD_BANKED_PFX 1'b0
`define DD_FIXED_PFX  3'b100

`endif

//--- logic/dd_map_pkg.sv
/* Address map types: decoded region and write register codes */

package dd_map_pkg;

    // Region hit by a bus cycle
    typedef enum logic [3:0] {
        region_none   = 4'd0,
        region_ram    = 4'd1,
        region_pal    = 4'd2,
        region_char   = 4'd3,
        region_com    = 4'd4,
        region_obj    = 4'd5,
        region_scr    = 4'd6,
        region_io     = 4'd7,
        region_rom    = 4'd8,   // Fixed window, 0x8000 up
        region_banked = 4'd9    // Paged window, 0x4000 to 0x7FFF
    } dd_region_e;

    // Write-only registers in the io block, A3 set
    typedef enum logic [3:0] {
        wreg_none      = 4'd0,
        wreg_misc      = 4'd1,
        wreg_hscr      = 4'd2,
        wreg_vscr      = 4'd3,
        wreg_nmi_clr   = 4'd4,
        wreg_firq_clr  = 4'd5,
        wreg_irq_clr   = 4'd6,
        wreg_snd_latch = 4'd7,
        wreg_mcu_nmi   = 4'd8
    } dd_wreg_e;

endpackage

//--- logic/dd_io_pkg.sv
/* Cabinet I/O types: input port codes and misc register layout */

`include "dd_bus_cfg.svh"

package dd_io_pkg;

    // Misc register, MSB first
    typedef struct packed {
        logic [`DD_BANK_W-1:0] bank;
        logic                  mcu_halt;
        logic                  snd_rstb;
        logic                  flip;
        logic                  vscr_hi;   // V scroll bit 8
        logic                  hscr_hi;   // H scroll bit 8
    } dd_misc_t;

    // Cabinet read ports, selected by A[3:0]
    typedef enum logic [3:0] {
        port_p1   = 4'd0,
        port_p2   = 4'd1,
        port_sys  = 4'd2,
        port_dipa = 4'd3,
        port_dipb = 4'd4
    } dd_io_port_e;

endpackage

//--- logic/dd_addr_decode.sv
/* Stage 1 address decoder: device selects, write register code, ROM address */

`include "dd_bus_cfg.svh"

module dd_addr_decode import dd_map_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_cen,
    input  logic [15:0]           addr,
    input  logic                  rnw,
    input  logic [7:0]            cpu_dout,
    input  logic [`DD_BANK_W-1:0] bank,
    output logic                  stb,
    output logic                  rd,
    output dd_region_e            region,
    output dd_wreg_e              wreg,
    output logic [7:0]            wdata,
    output logic [`DD_AB_W-1:0]   cpu_ab,
    output logic [`DD_ROM_AW-1:0] rom_addr,
    output logic                  ram_cs,
    output logic                  pal_cs,
    output logic                  char_cs,
    output logic                  com_cs,
    output logic                  obj_cs,
    output logic                  scr_cs,
    output logic                  rom_cs
);

    dd_region_e            region_d;
    dd_wreg_e              wreg_d;
    logic [`DD_ROM_AW-1:0] rom_addr_d;

    // Map decode
    always_comb begin
        region_d = region_none;
        wreg_d   = wreg_none;
        if (addr[15:14] == 2'b00) begin
            case (addr[13:11])
                3'd0, 3'd1: region_d = region_ram;
                3'd2:       region_d = region_pal;
                3'd3:       region_d = region_char;
                3'd4:       region_d = region_com;
                3'd5:       region_d = region_obj;
                3'd6:       region_d = region_scr;
                default:    region_d = region_io;
            endcase
            // Register writes need A3 high
            if (addr[13:11] == 3'd7 && !rnw && addr[3]) begin
                case (addr[2:0])
                    3'd0:    wreg_d = wreg_misc;
                    3'd1:    wreg_d = wreg_hscr;
                    3'd2:    wreg_d = wreg_vscr;
                    3'd3:    wreg_d = wreg_nmi_clr;
                    3'd4:    wreg_d = wreg_firq_clr;
                    3'd5:    wreg_d = wreg_irq_clr;
                    3'd6:    wreg_d = wreg_snd_latch;
                    default: wreg_d = wreg_mcu_nmi;
                endcase
            end
        end else if (!addr[15]) begin
            region_d = region_banked;
        end else begin
            region_d = region_rom;
        end
    end

    // Banked window pages through the bank register
    always_comb begin
        if (region_d == region_banked)
            rom_addr_d = {`DD_BANKED_PFX, bank, addr[13:0]};
        else
            rom_addr_d = {`DD_FIXED_PFX, addr[14], addr[13:0]};
    end

    // Control side, qualified by the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stb     <= 1'b0;
            rd      <= 1'b0;
            region  <= region_none;
            wreg    <= wreg_none;
            ram_cs  <= 1'b0;
            pal_cs  <= 1'b0;
            char_cs <= 1'b0;
            com_cs  <= 1'b0;
            obj_cs  <= 1'b0;
            scr_cs  <= 1'b0;
            rom_cs  <= 1'b0;
        end else begin
            stb     <= cpu_cen;
            rd      <= cpu_cen && rnw;
            region  <= cpu_cen ? region_d : region_none;
            wreg    <= cpu_cen ? wreg_d : wreg_none;
            ram_cs  <= cpu_cen && region_d == region_ram;
            pal_cs  <= cpu_cen && region_d == region_pal;
            char_cs <= cpu_cen && region_d == region_char;
            com_cs  <= cpu_cen && region_d == region_com;
            obj_cs  <= cpu_cen && region_d == region_obj;
            scr_cs  <= cpu_cen && region_d == region_scr;
            rom_cs  <= cpu_cen && (region_d == region_rom || region_d == region_banked);
        end
    end

    // Payload, held between cycles
    always_ff @(posedge clk) begin
        if (cpu_cen) begin
            wdata    <= cpu_dout;
            cpu_ab   <= addr[`DD_AB_W-1:0];
            rom_addr <= rom_addr_d;
        end
    end

endmodule

//--- logic/dd_ctrl_regs.sv
/* Write-only control registers, sound latch, MCU NMI and interrupt clear pulses */

`include "dd_bus_cfg.svh"

module dd_ctrl_regs import dd_map_pkg::*, dd_io_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stb,
    input  dd_wreg_e                wreg,
    input  logic [7:0]              wdata,
    output logic [`DD_SCROLL_W-1:0] scrhpos,
    output logic [`DD_SCROLL_W-1:0] scrvpos,
    output logic                    flip,
    output logic                    snd_rstb,
    output logic                    mcu_halt,
    output logic [`DD_BANK_W-1:0]   bank,
    output logic [7:0]              snd_latch,
    output logic                    snd_irq,
    output logic                    mcu_nmi_set,
    output logic                    nmi_clr,
    output logic                    firq_clr,
    output logic                    irq_clr
);

    dd_misc_t misc;

    assign misc = dd_misc_t'(wdata);

    // Clears act on the same edge as the register writes
    assign nmi_clr  = stb && wreg == wreg_nmi_clr;
    assign firq_clr = stb && wreg == wreg_firq_clr;
    assign irq_clr  = stb && wreg == wreg_irq_clr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scrhpos     <= '0;
            scrvpos     <= '0;
            flip        <= 1'b0;
            snd_rstb    <= 1'b0;
            mcu_halt    <= 1'b0;
            bank        <= '0;
            snd_irq     <= 1'b0;
            mcu_nmi_set <= 1'b0;
        end else begin
            // One-cycle pulses
            snd_irq     <= stb && wreg == wreg_snd_latch;
            mcu_nmi_set <= stb && wreg == wreg_mcu_nmi;
            if (stb) begin
                case (wreg)
                    wreg_hscr: scrhpos[7:0] <= wdata;
                    wreg_vscr: scrvpos[7:0] <= wdata;
                    wreg_misc: begin
                        // Scroll bit 8 lives in misc
                        scrhpos[`DD_SCROLL_W-1] <= misc.hscr_hi;
                        scrvpos[`DD_SCROLL_W-1] <= misc.vscr_hi;
                        flip     <= misc.flip;
                        snd_rstb <= misc.snd_rstb;
                        mcu_halt <= misc.mcu_halt;
                        bank     <= misc.bank;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Latch for the sound CPU
    always_ff @(posedge clk) begin
        if (stb && wreg == wreg_snd_latch)
            snd_latch <= wdata;
    end

endmodule

//--- logic/dd_irq_latch.sv
/* NMI, FIRQ and IRQ edge latches with register clears */

module dd_irq_latch (
    input  logic clk,
    input  logic rst,
    input  logic vbl,
    input  logic dip_pause,
    input  logic ims,
    input  logic mcu_irqmain,
    input  logic nmi_clr,
    input  logic firq_clr,
    input  logic irq_clr,
    output logic nmi_n,
    output logic firq_n,
    output logic irq_n
);

    // Bit order NMI, FIRQ, IRQ
    logic [2:0] src;
    logic [2:0] src_l;
    logic [2:0] clr;
    logic [2:0] pend;

    // Pause switch masks the VBL interrupt
    assign src = {vbl & dip_pause, ims, mcu_irqmain};
    assign clr = {nmi_clr, firq_clr, irq_clr};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_l <= '0;
            pend  <= '0;
        end else begin
            src_l <= src;
            // Set has priority over a simultaneous clear
            pend  <= (src & ~src_l) | (pend & ~clr);
        end
    end

    assign nmi_n  = ~pend[2];
    assign firq_n = ~pend[1];
    assign irq_n  = ~pend[0];

endmodule

//--- logic/dd_cabinet_in.sv
/* Cabinet input formatting: joysticks, buttons, coins and DIP switches */

module dd_cabinet_in import dd_io_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_cen,
    input  logic       rnw,
    input  logic [15:0] addr,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic [6:0] joystick1,
    input  logic [6:0] joystick2,
    input  logic       mcu_ban,
    input  logic       vbl,
    input  logic       dip_test,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b,
    output logic [7:0] cab_dout
);

    logic io_rd;

    // Up and down swap places on the board
    function automatic logic [5:0] fix_joy(input logic [5:0] joy);
        return {joy[5:4], joy[2], joy[3], joy[1:0]};
    endfunction

    // io block, 0x3800 to 0x3FFF
    assign io_rd = cpu_cen && rnw && addr[15:14] == 2'b00 && addr[13:11] == 3'd7;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
        end else if (io_rd) begin
            case (dd_io_port_e'(addr[3:0]))
                port_p1:   cab_dout <= {start_button, fix_joy(joystick1[5:0])};
                port_p2:   cab_dout <= {coin_input, fix_joy(joystick2[5:0])};
                // Upper bits float high
                port_sys:  cab_dout <= {3'b111, mcu_ban, vbl,
                                        joystick2[6], joystick1[6], dip_test};
                port_dipa: cab_dout <= dipsw_a;
                port_dipb: cab_dout <= dipsw_b;
                default:   cab_dout <= 8'hff;
            endcase
        end
    end

endmodule

//--- logic/dd_read_mux.sv
/* Registered CPU read data select */

module dd_read_mux import dd_map_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stb,
    input  logic       rd,
    input  dd_region_e region,
    input  logic [7:0] ram_dout,
    input  logic [7:0] pal_dout,
    input  logic [7:0] char_dout,
    input  logic [7:0] mcu_ram,
    input  logic [7:0] obj_dout,
    input  logic [7:0] scr_dout,
    input  logic [7:0] rom_data,
    input  logic [7:0] cab_dout,
    output logic [7:0] cpu_din
);

    // Held until the next strobed read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 8'hff;
        end else if (stb && rd) begin
            case (region)
                region_ram:    cpu_din <= ram_dout;
                region_com:    cpu_din <= mcu_ram;   // Shared with the MCU
                region_pal:    cpu_din <= pal_dout;
                region_char:   cpu_din <= char_dout;
                region_obj:    cpu_din <= obj_dout;
                region_scr:    cpu_din <= scr_dout;
                region_rom,
                region_banked: cpu_din <= rom_data;
                region_io:     cpu_din <= cab_dout;
                default:       cpu_din <= 8'hff;
            endcase
        end
    end

endmodule

//--- logic/dd_main_bus.sv
/* Main CPU bus controller top level */

`include "dd_bus_cfg.svh"

module dd_main_bus import dd_map_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // CPU bus
    input  logic                    cpu_cen,
    input  logic [15:0]             addr,
    input  logic                    rnw,
    input  logic [7:0]              cpu_dout,
    output logic [7:0]              cpu_din,
    output logic [`DD_AB_W-1:0]     cpu_ab,
    output logic                    nmi_n,
    output logic                    firq_n,
    output logic                    irq_n,
    // Interrupt sources
    input  logic                    vbl,
    input  logic                    ims,
    input  logic                    dip_pause,
    // MCU
    input  logic [7:0]              mcu_ram,
    input  logic                    mcu_irqmain,
    input  logic                    mcu_ban,
    output logic                    mcu_nmi_set,
    output logic                    mcu_halt,
    output logic                    com_cs,
    // Devices
    output logic                    ram_cs,
    input  logic [7:0]              ram_dout,
    output logic                    pal_cs,
    input  logic [7:0]              pal_dout,
    output logic                    char_cs,
    input  logic [7:0]              char_dout,
    output logic                    obj_cs,
    input  logic [7:0]              obj_dout,
    output logic                    scr_cs,
    input  logic [7:0]              scr_dout,
    output logic                    rom_cs,
    output logic [`DD_ROM_AW-1:0]   rom_addr,
    input  logic [7:0]              rom_data,
    // Video and sound control
    output logic                    flip,
    output logic [`DD_SCROLL_W-1:0] scrhpos,
    output logic [`DD_SCROLL_W-1:0] scrvpos,
    output logic                    snd_rstb,
    output logic                    snd_irq,
    output logic [7:0]              snd_latch,
    // Cabinet
    input  logic [1:0]              start_button,
    input  logic [1:0]              coin_input,
    input  logic [6:0]              joystick1,
    input  logic [6:0]              joystick2,
    input  logic                    dip_test,
    input  logic [7:0]              dipsw_a,
    input  logic [7:0]              dipsw_b
);

    logic                  stb;
    logic                  rd;
    dd_region_e            region;
    dd_wreg_e              wreg;
    logic [7:0]            wdata;
    logic [`DD_BANK_W-1:0] bank;
    logic [7:0]            cab_dout;
    logic                  nmi_clr;
    logic                  firq_clr;
    logic                  irq_clr;

    // Stage 1
    dd_addr_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .addr     (addr),
        .rnw      (rnw),
        .cpu_dout (cpu_dout),
        .bank     (bank),
        .stb      (stb),
        .rd       (rd),
        .region   (region),
        .wreg     (wreg),
        .wdata    (wdata),
        .cpu_ab   (cpu_ab),
        .rom_addr (rom_addr),
        .ram_cs   (ram_cs),
        .pal_cs   (pal_cs),
        .char_cs  (char_cs),
        .com_cs   (com_cs),
        .obj_cs   (obj_cs),
        .scr_cs   (scr_cs),
        .rom_cs   (rom_cs)
    );

    // Stage 2 write side
    dd_ctrl_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .stb         (stb),
        .wreg        (wreg),
        .wdata       (wdata),
        .scrhpos     (scrhpos),
        .scrvpos     (scrvpos),
        .flip        (flip),
        .snd_rstb    (snd_rstb),
        .mcu_halt    (mcu_halt),
        .bank        (bank),
        .snd_latch   (snd_latch),
        .snd_irq     (snd_irq),
        .mcu_nmi_set (mcu_nmi_set),
        .nmi_clr     (nmi_clr),
        .firq_clr    (firq_clr),
        .irq_clr     (irq_clr)
    );

    dd_irq_latch u_irq (
        .clk         (clk),
        .rst         (rst),
        .vbl         (vbl),
        .dip_pause   (dip_pause),
        .ims         (ims),
        .mcu_irqmain (mcu_irqmain),
        .nmi_clr     (nmi_clr),
        .firq_clr    (firq_clr),
        .irq_clr     (irq_clr),
        .nmi_n       (nmi_n),
        .firq_n      (firq_n),
        .irq_n       (irq_n)
    );

    // Sampled alongside stage 1
    dd_cabinet_in u_cab (
        .clk          (clk),
        .rst          (rst),
        .cpu_cen      (cpu_cen),
        .rnw          (rnw),
        .addr         (addr),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .mcu_ban      (mcu_ban),
        .vbl          (vbl),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout)
    );

    // Stage 2 read side
    dd_read_mux u_rmux (
        .clk       (clk),
        .rst       (rst),
        .stb       (stb),
        .rd        (rd),
        .region    (region),
        .ram_dout  (ram_dout),
        .pal_dout  (pal_dout),
        .char_dout (char_dout),
        .mcu_ram   (mcu_ram),
        .obj_dout  (obj_dout),
        .scr_dout  (scr_dout),
        .rom_data  (rom_data),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din)
    );

endmodule

//--- bench/dd_main_bus_asserts.sv
/* Bus controller assertions: select exclusivity, pulse width, ROM select source */

module dd_main_bus_asserts (
    input logic        clk,
    input logic        rst,
    input logic        cpu_cen,
    input logic [15:0] addr,
    input logic        ram_cs,
    input logic        pal_cs,
    input logic        char_cs,
    input logic        com_cs,
    input logic        obj_cs,
    input logic        scr_cs,
    input logic        rom_cs,
    input logic        snd_irq,
    input logic        mcu_nmi_set
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [6:0] sel;

    // Failure count for the closing line
    int assert_fails = 0;

    assign sel = {rom_cs, scr_cs, obj_cs, com_cs, char_cs, pal_cs, ram_cs};

    // Only one device on the bus per cycle
    a_one_select: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else begin
            $error("more than one device select high: %b", sel);
            assert_fails++;
        end

    // Single-cycle pulses
    a_snd_irq_pulse: assert property (@(posedge clk) disable iff (rst) snd_irq |=> !snd_irq)
        else begin
            $error("snd_irq held for two cycles");
            assert_fails++;
        end

    a_mcu_nmi_pulse: assert property (@(posedge clk) disable iff (rst)
        mcu_nmi_set |=> !mcu_nmi_set)
        else begin
            $error("mcu_nmi_set held for two cycles");
            assert_fails++;
        end

    // ROM select follows a strobe above 0x3FFF
    a_rom_source: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> $past(cpu_cen && addr[15:14] != 2'b00))
        else begin
            $error("rom_cs without a ROM window strobe");
            assert_fails++;
        end

endmodule

bind dd_main_bus dd_main_bus_asserts asserts_i (
    .clk         (clk),
    .rst         (rst),
    .cpu_cen     (cpu_cen),
    .addr        (addr),
    .ram_cs      (ram_cs),
    .pal_cs      (pal_cs),
    .char_cs     (char_cs),
    .com_cs      (com_cs),
    .obj_cs      (obj_cs),
    .scr_cs      (scr_cs),
    .rom_cs      (rom_cs),
    .snd_irq     (snd_irq),
    .mcu_nmi_set (mcu_nmi_set)
);

//--- bench/dd_main_bus_tb.sv
/* Bus controller testbench with clock, reset, device data, CPU bus tasks and directed tests */

`include "dd_bus_cfg.svh"

module dd_main_bus_tb import dd_io_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Fixed device read data
    localparam logic [7:0] ram_val  = 8'h1e;
    localparam logic [7:0] pal_val  = 8'h2d;
    localparam logic [7:0] char_val = 8'h3c;
    localparam logic [7:0] mcu_val  = 8'h4b;
    localparam logic [7:0] obj_val  = 8'h5a;
    localparam logic [7:0] scr_val  = 8'h69;
    localparam logic [7:0] rom_val  = 8'h78;

    // Signal codes for wait_for_level
    localparam int sig_nmi_n   = 0;
    localparam int sig_firq_n  = 1;
    localparam int sig_irq_n   = 2;
    localparam int sig_snd_irq = 3;
    localparam int sig_mcu_nmi = 4;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cpu_cen;
    logic [15:0]             addr;
    logic                    rnw;
    logic [7:0]              cpu_dout;
    logic [7:0]              cpu_din;
    logic [`DD_AB_W-1:0]     cpu_ab;
    logic                    nmi_n;
    logic                    firq_n;
    logic                    irq_n;
    logic                    vbl;
    logic                    ims;
    logic                    dip_pause;
    logic [7:0]              mcu_ram;
    logic                    mcu_irqmain;
    logic                    mcu_ban;
    logic                    mcu_nmi_set;
    logic                    mcu_halt;
    logic                    com_cs;
    logic                    ram_cs;
    logic [7:0]              ram_dout;
    logic                    pal_cs;
    logic [7:0]              pal_dout;
    logic                    char_cs;
    logic [7:0]              char_dout;
    logic                    obj_cs;
    logic [7:0]              obj_dout;
    logic                    scr_cs;
    logic [7:0]              scr_dout;
    logic                    rom_cs;
    logic [`DD_ROM_AW-1:0]   rom_addr;
    logic [7:0]              rom_data;
    logic                    flip;
    logic [`DD_SCROLL_W-1:0] scrhpos;
    logic [`DD_SCROLL_W-1:0] scrvpos;
    logic                    snd_rstb;
    logic                    snd_irq;
    logic [7:0]              snd_latch;
    logic [1:0]              start_button;
    logic [1:0]              coin_input;
    logic [6:0]              joystick1;
    logic [6:0]              joystick2;
    logic                    dip_test;
    logic [7:0]              dipsw_a;
    logic [7:0]              dipsw_b;

    int          errors    = 0;
    int          timeouts  = 0;
    int          bad_props = 0;
    logic [31:0] lcg_state = 32'd38;

    // Devices answer in the same cycle
    assign ram_dout  = ram_val;
    assign pal_dout  = pal_val;
    assign char_dout = char_val;
    assign mcu_ram   = mcu_val;
    assign obj_dout  = obj_val;
    assign scr_dout  = scr_val;
    assign rom_data  = rom_val;

    always #5ns clk = ~clk;

    dd_main_bus dd_main_bus_i (.*);

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic signal_level(input int which);
        case (which)
            sig_nmi_n:   return nmi_n;
            sig_firq_n:  return firq_n;
            sig_irq_n:   return irq_n;
            sig_snd_irq: return snd_irq;
            default:     return mcu_nmi_set;
        endcase
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Polls on falling edges and gives up after 20 cycles
    task automatic wait_for_level(input int which, input logic level, input string name);
        int n;
        n = 0;
        while (signal_level(which) !== level && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (signal_level(which) !== level) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s to become %0b", n, name, level);
        end
    endtask

    // One strobe entered and left on a falling edge
    task automatic bus_cycle(input logic [15:0] a, input logic read, input logic [7:0] d);
        cpu_cen  = 1'b1;
        addr     = a;
        rnw      = read;
        cpu_dout = d;
        @(negedge clk);
        cpu_cen  = 1'b0;
        rnw      = 1'b1;
    endtask

    // Select order rom, scr, obj, com, char, pal, ram
    task automatic bus_read(input logic [15:0] a, input logic [6:0] sel, input logic [7:0] exp);
        logic [6:0] cs;
        bus_cycle(a, 1'b1, 8'h00);
        cs = {rom_cs, scr_cs, obj_cs, com_cs, char_cs, pal_cs, ram_cs};
        if (cs !== sel)
            flag_error($sformatf("read 0x%h selects %b, expected %b", a, cs, sel));
        if (cpu_ab !== a[`DD_AB_W-1:0])
            flag_error($sformatf("read 0x%h drives cpu_ab 0x%h", a, cpu_ab));
        @(negedge clk);
        if (cpu_din !== exp)
            flag_error($sformatf("read 0x%h returns 0x%h, expected 0x%h", a, cpu_din, exp));
    endtask

    // Returns once the register is visible
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        bus_cycle(a, 1'b0, d);
        @(negedge clk);
    endtask

    task automatic check_reset_state();
        if ({ram_cs, pal_cs, char_cs, com_cs, obj_cs, scr_cs, rom_cs} !== 7'b0)
            flag_error("device select high after reset");
        if ({snd_irq, mcu_nmi_set, snd_rstb, mcu_halt} !== 4'b0)
            flag_error("sound or MCU control high after reset");
        if ({nmi_n, firq_n, irq_n} !== 3'b111)
            flag_error("interrupt output low after reset");
        if (scrhpos !== '0 || scrvpos !== '0 || flip !== 1'b0)
            flag_error("scroll or flip not cleared by reset");
        if (cpu_din !== 8'hff)
            flag_error($sformatf("cpu_din is 0x%h after reset", cpu_din));
    endtask

    task automatic read_each_region();
        bus_read(16'h0123, 7'b0000001, ram_val);
        bus_read(16'h0a55, 7'b0000001, ram_val);
        bus_read(16'h1234, 7'b0000010, pal_val);
        bus_read(16'h1a02, 7'b0000100, char_val);
        bus_read(16'h2345, 7'b0001000, mcu_val);
        bus_read(16'h2c10, 7'b0010000, obj_val);
        bus_read(16'h3456, 7'b0100000, scr_val);
        // Idle port 0 reads zero ahead of the unmapped port
        bus_read(16'h3800, 7'b0000000, 8'h00);
        // Port 7 has no cabinet byte
        bus_read(16'h3807, 7'b0000000, 8'hff);
        // Bank still zero from reset
        bus_read(16'h4abc, 7'b1000000, rom_val);
        if (rom_addr !== {1'b0, 3'd0, 14'h0abc})
            flag_error($sformatf("banked rom_addr 0x%h after reset", rom_addr));
        bus_read(16'h8001, 7'b1000000, rom_val);
        if (rom_addr !== {3'b100, 1'b0, 14'h0001})
            flag_error($sformatf("fixed rom_addr 0x%h", rom_addr));
    endtask

    task automatic write_ctrl_and_bank();
        dd_misc_t misc_val;
        misc_val          = '0;
        misc_val.bank     = 3'd5;
        misc_val.mcu_halt = 1'b1;
        misc_val.snd_rstb = 1'b1;
        misc_val.flip     = 1'b1;
        misc_val.hscr_hi  = 1'b1;
        bus_write(16'h3809, 8'ha7);
        bus_write(16'h380a, 8'h3c);
        bus_write(16'h3808, misc_val);
        if (scrhpos !== {1'b1, 8'ha7} || scrvpos !== {1'b0, 8'h3c})
            flag_error($sformatf("scroll H 0x%h V 0x%h", scrhpos, scrvpos));
        if ({flip, snd_rstb, mcu_halt} !== 3'b111)
            flag_error("flip, snd_rstb or mcu_halt not set by misc");
        // Bank 5 pages the 0x4000 window
        bus_read(16'h5234, 7'b1000000, rom_val);
        if (rom_addr !== {1'b0, 3'd5, 14'h1234})
            flag_error($sformatf("banked rom_addr 0x%h with bank 5", rom_addr));
        bus_read(16'hc321, 7'b1000000, rom_val);
        if (rom_addr !== {3'b100, 1'b1, 14'h0321})
            flag_error($sformatf("fixed rom_addr 0x%h", rom_addr));
    endtask

    task automatic pulse_sound_and_mcu();
        bus_write(16'h380e, 8'h96);
        wait_for_level(sig_snd_irq, 1'b1, "snd_irq");
        if (snd_latch !== 8'h96)
            flag_error($sformatf("snd_latch 0x%h, expected 0x96", snd_latch));
        @(negedge clk);
        if (snd_irq !== 1'b0)
            flag_error("snd_irq longer than one cycle");
        bus_write(16'h380f, 8'h00);
        wait_for_level(sig_mcu_nmi, 1'b1, "mcu_nmi_set");
        @(negedge clk);
        if (mcu_nmi_set !== 1'b0)
            flag_error("mcu_nmi_set longer than one cycle");
    endtask

    task automatic read_cabinet_ports();
        logic [31:0] r;
        logic [5:0]  j1s;
        logic [5:0]  j2s;
        for (int i = 0; i < 3; i++) begin
            r            = next_random();
            joystick1    = r[30:24];
            joystick2    = r[22:16];
            start_button = r[13:12];
            coin_input   = r[9:8];
            mcu_ban      = r[5];
            dip_test     = r[3];
            r            = next_random();
            dipsw_a      = r[31:24];
            dipsw_b      = r[23:16];
            // Up and down trade places
            j1s    = joystick1[5:0];
            j1s[2] = joystick1[3];
            j1s[3] = joystick1[2];
            j2s    = joystick2[5:0];
            j2s[2] = joystick2[3];
            j2s[3] = joystick2[2];
            bus_read({12'h380, port_p1}, 7'b0, {start_button, j1s});
            bus_read({12'h380, port_p2}, 7'b0, {coin_input, j2s});
            bus_read({12'h380, port_sys}, 7'b0,
                     {3'b111, mcu_ban, vbl, joystick2[6], joystick1[6], dip_test});
            bus_read({12'h380, port_dipa}, 7'b0, dipsw_a);
            bus_read({12'h380, port_dipb}, 7'b0, dipsw_b);
        end
    endtask

    task automatic raise_and_clear_irqs();
        ims = 1'b1;
        wait_for_level(sig_firq_n, 1'b0, "firq_n");
        mcu_irqmain = 1'b1;
        wait_for_level(sig_irq_n, 1'b0, "irq_n");
        // Pause switch off masks VBL
        dip_pause = 1'b0;
        vbl       = 1'b1;
        repeat (3) @(negedge clk);
        if (nmi_n !== 1'b1)
            flag_error("nmi_n fell with dip_pause low");
        vbl = 1'b0;
        @(negedge clk);
        dip_pause = 1'b1;
        @(negedge clk);
        vbl = 1'b1;
        wait_for_level(sig_nmi_n, 1'b0, "nmi_n");
        bus_write(16'h380b, 8'h00);
        wait_for_level(sig_nmi_n, 1'b1, "nmi_n");
        if (firq_n !== 1'b0 || irq_n !== 1'b0)
            flag_error("NMI clear also released FIRQ or IRQ");
        bus_write(16'h380c, 8'h00);
        wait_for_level(sig_firq_n, 1'b1, "firq_n");
        bus_write(16'h380d, 8'h00);
        wait_for_level(sig_irq_n, 1'b1, "irq_n");
    endtask

    initial begin
        rst          = 1'b1;
        cpu_cen      = 1'b0;
        addr         = 16'h0000;
        rnw          = 1'b1;
        cpu_dout     = 8'h00;
        vbl          = 1'b0;
        ims          = 1'b0;
        dip_pause    = 1'b0;
        mcu_irqmain  = 1'b0;
        mcu_ban      = 1'b0;
        start_button = 2'b00;
        coin_input   = 2'b00;
        joystick1    = 7'h00;
        joystick2    = 7'h00;
        dip_test     = 1'b0;
        dipsw_a      = 8'h00;
        dipsw_b      = 8'h00;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        read_each_region();
        write_ctrl_and_bank();
        pulse_sound_and_mcu();
        read_cabinet_ports();
        raise_and_clear_irqs();
        bad_props = dd_main_bus_i.asserts_i.assert_fails;
        $display("Run complete: %0d value errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, bad_props);
        if (errors == 0 && timeouts == 0 && bad_props == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/dd_map_pkg.sv
logic/dd_io_pkg.sv
logic/dd_addr_decode.sv
logic/dd_ctrl_regs.sv
logic/dd_irq_latch.sv
logic/dd_cabinet_in.sv
logic/dd_read_mux.sv
logic/dd_main_bus.sv
bench/dd_main_bus_asserts.sv
bench/dd_main_bus_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := dd_main_bus_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
